/* src/apuPkg.sv */
// ----------------------------------------------------------
// Pulse subsystem constants, shared types and lookup tables
// Only the two pulse channels exist, other status bits read 0
// ----------------------------------------------------------
`default_nettype none

package apuPkg;

  // ----------------------------------------------------------
  // Register map, 5-bit CPU address
  // ----------------------------------------------------------
  localparam logic [4:0] REG_PULSE1 = 5'h00;  // Group 0, regs 0x00-0x03
  localparam logic [4:0] REG_PULSE2 = 5'h04;  // Group 1, regs 0x04-0x07
  localparam logic [4:0] REG_STATUS = 5'h15;  // Enable write, status read
  localparam logic [4:0] REG_FRAME  = 5'h17;  // Frame counter control

  // Sequencer counts at which the frame pulses fire
  localparam logic [15:0] STEP1 = 16'd7457;
  localparam logic [15:0] STEP2 = 16'd14913;
  localparam logic [15:0] STEP3 = 16'd22371;
  localparam logic [15:0] STEP4 = 16'd29829;
  localparam logic [15:0] STEP5 = 16'd37281;

  typedef logic [3:0]  chanLevel_t;
  typedef logic [10:0] period_t;
  typedef logic [15:0] mixSample_t;

  typedef enum logic [1:0] {
    DUTY_12 = 2'd0,
    DUTY_25 = 2'd1,
    DUTY_50 = 2'd2,
    DUTY_75 = 2'd3   // Inverted 25%
  } dutyMode_e;

  typedef enum logic {
    FOUR_STEP = 1'b0,
    FIVE_STEP = 1'b1
  } frameMode_e;

  // Length load values, indexed by data bits 7:3 of register 3
  localparam logic [7:0] LEN_TABLE [32] = '{
    8'h0A, 8'hFE, 8'h14, 8'h02, 8'h28, 8'h04, 8'h50, 8'h06,
    8'hA0, 8'h08, 8'h3C, 8'h0A, 8'h0E, 8'h0C, 8'h1A, 8'h0E,
    8'h0C, 8'h10, 8'h18, 8'h12, 8'h30, 8'h14, 8'h60, 8'h16,
    8'hC0, 8'h18, 8'h48, 8'h1A, 8'h10, 8'h1C, 8'h20, 8'h1E
  };

  // Nonlinear pulse mix, indexed by the sum of both levels
  localparam logic [15:0] PULSE_TABLE [31] = '{
    16'd0,     16'd760,   16'd1503,  16'd2228,  16'd2936,  16'd3627,
    16'd4303,  16'd4963,  16'd5609,  16'd6240,  16'd6858,  16'd7462,
    16'd8053,  16'd8631,  16'd9198,  16'd9752,  16'd10296, 16'd10828,
    16'd11349, 16'd11860, 16'd12361, 16'd12852, 16'd13334, 16'd13807,
    16'd14270, 16'd14725, 16'd15171, 16'd15609, 16'd16039, 16'd16461,
    16'd16876
  };

endpackage

`default_nettype wire

/* src/apuChanBus.sv */
// ----------------------------------------------------------
// Register write path from the decoder to one pulse channel
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface apuChanBus;

  logic       wr;       // One-cycle write strobe
  logic [1:0] regSel;   // Register 0..3 inside the channel
  logic [7:0] data;     // Write data
  logic [7:0] lenLoad;  // Length counter load value

  // Decoder side
  modport decoder (
    output wr,
    output regSel,
    output data,
    output lenLoad
  );

  // Channel side
  modport chan (
    input wr,
    input regSel,
    input data,
    input lenLoad
  );

endinterface

`default_nettype wire

/* src/apuRegDecode.sv */
// ----------------------------------------------------------
// CPU write decode, strobes are combinational from addr/mw
// Frame fields show the written value during the write cycle
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module apuRegDecode import apuPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        ce,
  input  logic [4:0]  addr,
  input  logic [7:0]  din,
  input  logic        mw,
  input  logic        mr,
  apuChanBus.decoder  pulse1Bus,
  apuChanBus.decoder  pulse2Bus,
  output logic [1:0]  enable,
  output logic        frameWr,
  output frameMode_e  frameMode,
  output logic        irqInhibit,
  output logic        statusRead
);

  frameMode_e modeQ;     // Held frame mode
  logic       inhibitQ;  // Held interrupt inhibit
  logic [7:0] lenLoad;

  assign lenLoad = LEN_TABLE[din[7:3]];

  // Channel write paths
  assign pulse1Bus.wr      = mw && (addr[4:2] == REG_PULSE1[4:2]);
  assign pulse1Bus.regSel  = addr[1:0];
  assign pulse1Bus.data    = din;
  assign pulse1Bus.lenLoad = lenLoad;

  assign pulse2Bus.wr      = mw && (addr[4:2] == REG_PULSE2[4:2]);
  assign pulse2Bus.regSel  = addr[1:0];
  assign pulse2Bus.data    = din;
  assign pulse2Bus.lenLoad = lenLoad;

  assign frameWr    = mw && (addr == REG_FRAME);
  assign statusRead = mr && (addr == REG_STATUS);

  // New fields are visible to the sequencer on the write cycle itself
  assign frameMode  = frameWr ? frameMode_e'(din[7]) : modeQ;
  assign irqInhibit = frameWr ? din[6] : inhibitQ;

  always_ff @(posedge clk) begin
    if (reset) begin
      enable   <= 2'b00;
      modeQ    <= FOUR_STEP;
      inhibitQ <= 1'b0;
    end else if (ce) begin
      if (mw && (addr == REG_STATUS))
        enable <= din[1:0];  // Bits 2..4 have no channel
      if (frameWr) begin
        modeQ    <= frameMode_e'(din[7]);
        inhibitQ <= din[6];
      end
    end
  end

  // Only one channel may see a given write
  assert property (@(posedge clk) disable iff (reset)
    !(pulse1Bus.wr && pulse2Bus.wr));

endmodule

`default_nettype wire

/* src/apuFrameSeq.sv */
// ----------------------------------------------------------
// Frame sequencer, 4-step and 5-step modes, counts ce cycles
// Frame flag stays clear while the interrupt is inhibited
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module apuFrameSeq import apuPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       ce,
  input  logic       frameWr,
  input  frameMode_e frameMode,
  input  logic       irqInhibit,
  input  logic       statusRead,
  output logic       quarterClk,
  output logic       halfClk,
  output logic       oddEven,
  output logic       irq
);

  logic [15:0] stepCnt;
  logic        delayedWr;  // Frame write seen on an odd phase
  logic [1:0]  irqCnt;     // Holds the flag after step 4
  logic        frameFlag;
  logic        flagNext;
  logic        restart;

  assign restart = delayedWr || (frameWr && !oddEven);

  always_comb begin
    flagNext = frameFlag;
    if (statusRead)
      flagNext = 1'b0;
    if (irqCnt[1])
      flagNext = 1'b1;  // A read cannot clear it yet
    if ((stepCnt == STEP4) && (frameMode == FOUR_STEP))
      flagNext = 1'b1;
    if (irqInhibit)
      flagNext = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stepCnt    <= 16'd4;
      oddEven    <= 1'b0;
      delayedWr  <= 1'b0;
      irqCnt     <= 2'b00;
      frameFlag  <= 1'b0;
      quarterClk <= 1'b0;
      halfClk    <= 1'b0;
    end else if (ce) begin
      frameFlag  <= flagNext;
      oddEven    <= ~oddEven;
      irqCnt     <= {irqCnt[0], 1'b0};
      stepCnt    <= stepCnt + 16'd1;
      quarterClk <= 1'b0;
      halfClk    <= 1'b0;

      // ------------------------------------------------------------
      // Step decode
      // ------------------------------------------------------------
      case (stepCnt)
        STEP1, STEP3: quarterClk <= 1'b1;
        STEP2: begin
          quarterClk <= 1'b1;
          halfClk    <= 1'b1;
        end
        STEP4: begin
          if (frameMode == FOUR_STEP) begin
            quarterClk <= 1'b1;
            halfClk    <= 1'b1;
            stepCnt    <= 16'd0;
            irqCnt     <= 2'b11;
          end
        end
        STEP5: begin  // Only reachable in 5-step mode
          quarterClk <= 1'b1;
          halfClk    <= 1'b1;
          stepCnt    <= 16'd0;
        end
        default: ;
      endcase

      // Frame write, immediate on even phase, one cycle late on odd
      delayedWr <= frameWr && oddEven;
      if (restart) begin
        stepCnt <= 16'd0;
        if (frameMode == FIVE_STEP) begin
          quarterClk <= 1'b1;
          halfClk    <= 1'b1;
        end
      end
    end
  end

  assign irq = frameFlag;

  assert property (@(posedge clk) disable iff (reset) halfClk |-> quarterClk);

endmodule

`default_nettype wire

/* src/apuPulseChan.sv */
// ----------------------------------------------------------
// Pulse channel, register writes act on the next ce cycle
// SECOND_PULSE picks the two's-complement negative sweep
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module apuPulseChan import apuPkg::*; #(
  parameter bit SECOND_PULSE = 1'b0
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       ce,
  input  logic       enable,
  input  logic       quarterClk,
  input  logic       halfClk,
  apuChanBus.chan    bus,
  output chanLevel_t level,
  output logic       lenActive
);

  // Register 0
  dutyMode_e   duty;
  logic        envLoop;     // Also halts the length counter
  logic        constVol;
  logic [3:0]  volume;
  // Register 1
  logic        sweepEn;
  logic [2:0]  sweepPeriod;
  logic        sweepNeg;
  logic [2:0]  sweepShift;
  logic        sweepReload;
  logic [2:0]  sweepDiv;
  // Timer and sequencer
  period_t     period;
  logic [11:0] timer;
  logic [2:0]  seqPos;
  // Length and envelope
  logic [7:0]  lenCnt;
  logic        envStart;
  logic [3:0]  envDiv;
  logic [3:0]  envVol;
  // Sweep target
  period_t     shifted;
  period_t     adjust;
  logic [11:0] target;
  logic        validFreq;
  logic        dutyHigh;

  assign shifted   = period >> sweepShift;
  assign adjust    = sweepNeg ? (~shifted + {10'd0, SECOND_PULSE}) : shifted;
  assign target    = {1'b0, period} + {1'b0, adjust};
  assign validFreq = (period >= 11'd8) && (sweepNeg || !target[11]);
  assign lenActive = (lenCnt != 8'd0);

  always_ff @(posedge clk) begin
    if (reset) begin
      duty        <= DUTY_12;
      envLoop     <= 1'b0;
      constVol    <= 1'b0;
      volume      <= 4'd0;
      sweepEn     <= 1'b0;
      sweepPeriod <= 3'd0;
      sweepNeg    <= 1'b0;
      sweepShift  <= 3'd0;
      sweepReload <= 1'b0;
      sweepDiv    <= 3'd0;
      period      <= '0;
      timer       <= 12'd0;
      seqPos      <= 3'd0;
      lenCnt      <= 8'd0;
      envStart    <= 1'b0;
      envDiv      <= 4'd0;
      envVol      <= 4'd0;
    end else if (ce) begin
      // ------------------------------------------------------------
      // Register writes, the clocked units below take priority
      // ------------------------------------------------------------
      if (bus.wr) begin
        case (bus.regSel)
          2'd0: begin
            duty     <= dutyMode_e'(bus.data[7:6]);
            envLoop  <= bus.data[5];
            constVol <= bus.data[4];
            volume   <= bus.data[3:0];
          end
          2'd1: begin
            sweepEn     <= bus.data[7];
            sweepPeriod <= bus.data[6:4];
            sweepNeg    <= bus.data[3];
            sweepShift  <= bus.data[2:0];
            sweepReload <= 1'b1;
          end
          2'd2: period[7:0] <= bus.data;
          2'd3: begin
            period[10:8] <= bus.data[2:0];
            lenCnt       <= bus.lenLoad;
            envStart     <= 1'b1;
            seqPos       <= 3'd0;
          end
          default: ;
        endcase
      end

      // Timer steps the duty sequencer backward
      if (timer == 12'd0) begin
        timer  <= {period, 1'b1};
        seqPos <= seqPos - 3'd1;
      end else begin
        timer <= timer - 12'd1;
      end

      if (halfClk) begin
        if (lenActive && !envLoop)
          lenCnt <= lenCnt - 8'd1;
        if (sweepDiv == 3'd0) begin
          sweepDiv <= sweepPeriod;
          if (sweepEn && (sweepShift != 3'd0) && validFreq)
            period <= target[10:0];
        end else begin
          sweepDiv <= sweepDiv - 3'd1;
        end
        if (sweepReload)
          sweepDiv <= sweepPeriod;
        sweepReload <= 1'b0;
      end

      if (quarterClk) begin
        if (envStart) begin
          envDiv   <= volume;
          envVol   <= 4'd15;
          envStart <= 1'b0;
        end else if (envDiv == 4'd0) begin
          envDiv <= volume;
          if ((envVol != 4'd0) || envLoop)
            envVol <= envVol - 4'd1;  // Wraps to 15 when looping
        end else begin
          envDiv <= envDiv - 4'd1;
        end
      end

      if (!enable)
        lenCnt <= 8'd0;  // Disabled channel loses its length
    end
  end

  // Output level
  always_comb begin
    case (duty)
      DUTY_12: dutyHigh = (seqPos == 3'd7);
      DUTY_25: dutyHigh = (seqPos >= 3'd6);
      DUTY_50: dutyHigh = (seqPos >= 3'd4);
      DUTY_75: dutyHigh = (seqPos < 3'd6);
    endcase
    if (!lenActive || !validFreq || !dutyHigh)
      level = 4'd0;
    else
      level = constVol ? volume : envVol;
  end

  // Enable from the status register clears the length counter
  assert property (@(posedge clk) disable iff (reset)
    (ce && !enable) |=> (lenCnt == 8'd0));

endmodule

`default_nettype wire

/* src/apuMixer.sv */
// ----------------------------------------------------------
// Pulse mixer and status byte, sample lags levels by a cycle
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module apuMixer import apuPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       ce,
  input  logic [1:0] chanMask,    // Bit n passes channel n+1
  input  chanLevel_t level1,
  input  chanLevel_t level2,
  input  logic       lenActive1,
  input  logic       lenActive2,
  input  logic       frameIrq,
  output mixSample_t sample,
  output logic [7:0] dout
);

  logic [4:0] mix1;
  logic [4:0] mix2;
  logic [4:0] mixSum;  // At most 30

  assign mix1   = chanMask[0] ? {1'b0, level1} : 5'd0;
  assign mix2   = chanMask[1] ? {1'b0, level2} : 5'd0;
  assign mixSum = mix1 + mix2;

  // ----------------------------------------------------------
  // Table lookup
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset)
      sample <= '0;
    else if (ce)
      sample <= PULSE_TABLE[mixSum];
  end

  // Status byte
  assign dout = {
    1'b0,        // No DMC interrupt
    frameIrq,
    4'b0000,     // DMC, noise, triangle absent
    lenActive2,
    lenActive1
  };

endmodule

`default_nettype wire

/* src/apuTop.sv */
// ----------------------------------------------------------
// Two-channel pulse sound unit, all state advances on ce
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module apuTop import apuPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       ce,
  input  logic [4:0] addr,
  input  logic [7:0] din,
  input  logic       mw,
  input  logic       mr,
  input  logic [1:0] chanMask,
  output logic [7:0] dout,
  output mixSample_t sample,
  output logic       irq,
  output logic       oddEven
);

  apuChanBus pulse1Bus ();
  apuChanBus pulse2Bus ();

  logic [1:0] enable;
  logic       frameWr;
  frameMode_e frameMode;
  logic       irqInhibit;
  logic       statusRead;
  logic       quarterClk;
  logic       halfClk;
  chanLevel_t level1;
  chanLevel_t level2;
  logic       lenActive1;
  logic       lenActive2;

  // ----------------------------------------------------------
  // Input side
  // ----------------------------------------------------------
  apuRegDecode regDecode (
    .clk, .reset, .ce, .addr, .din, .mw, .mr,
    .pulse1Bus (pulse1Bus.decoder),
    .pulse2Bus (pulse2Bus.decoder),
    .enable, .frameWr, .frameMode, .irqInhibit, .statusRead
  );

  apuFrameSeq frameSeq (
    .clk, .reset, .ce, .frameWr, .frameMode, .irqInhibit, .statusRead,
    .quarterClk, .halfClk, .oddEven, .irq
  );

  // Channel 1 uses ones'-complement sweep, channel 2 two's
  apuPulseChan #(.SECOND_PULSE(1'b0)) pulse1 (
    .clk, .reset, .ce, .enable (enable[0]), .quarterClk, .halfClk,
    .bus (pulse1Bus.chan), .level (level1), .lenActive (lenActive1)
  );

  apuPulseChan #(.SECOND_PULSE(1'b1)) pulse2 (
    .clk, .reset, .ce, .enable (enable[1]), .quarterClk, .halfClk,
    .bus (pulse2Bus.chan), .level (level2), .lenActive (lenActive2)
  );

  apuMixer mixer (
    .clk, .reset, .ce, .chanMask, .level1, .level2,
    .lenActive1, .lenActive2, .frameIrq (irq), .sample, .dout
  );

endmodule

`default_nettype wire

/* dv/apuTb.sv */
// ----------------------------------------------------------
// Random testbench for the pulse sound unit, ce held high
// Length loads are kept short so the run fits the cycle limit
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module apuTb;

  localparam int FRAME_CYCLES = 37282;
  localparam int CYCLE_LIMIT  = 12 * FRAME_CYCLES;
  localparam int S1 = 7457;
  localparam int S2 = 14913;
  localparam int S3 = 22371;
  localparam int S4 = 29829;
  localparam int S5 = 37281;

  logic [7:0]  lenRef [32] = '{
    8'h0A, 8'hFE, 8'h14, 8'h02, 8'h28, 8'h04, 8'h50, 8'h06,
    8'hA0, 8'h08, 8'h3C, 8'h0A, 8'h0E, 8'h0C, 8'h1A, 8'h0E,
    8'h0C, 8'h10, 8'h18, 8'h12, 8'h30, 8'h14, 8'h60, 8'h16,
    8'hC0, 8'h18, 8'h48, 8'h1A, 8'h10, 8'h1C, 8'h20, 8'h1E
  };
  logic [15:0] pulseRef [31] = '{
    16'd0,     16'd760,   16'd1503,  16'd2228,  16'd2936,  16'd3627,
    16'd4303,  16'd4963,  16'd5609,  16'd6240,  16'd6858,  16'd7462,
    16'd8053,  16'd8631,  16'd9198,  16'd9752,  16'd10296, 16'd10828,
    16'd11349, 16'd11860, 16'd12361, 16'd12852, 16'd13334, 16'd13807,
    16'd14270, 16'd14725, 16'd15171, 16'd15609, 16'd16039, 16'd16461,
    16'd16876
  };

  logic        clk;
  logic        reset;
  logic        ce;
  logic [4:0]  addr;
  logic [7:0]  din;
  logic        mw;
  logic        mr;
  logic [1:0]  chanMask;
  logic [7:0]  dout;
  logic [15:0] sample;
  logic        irq;
  logic        oddEven;

  // Reference model state
  int          mStep;
  logic        mOdd, mDelayed, mQuarter, mHalf, mFlag, mMode, mInhibit;
  int          mHold;
  logic [7:0]  mLen [2];
  logic [1:0]  mHalt;
  logic [1:0]  mEnable;
  int          halfSeen, quarterSeen;

  int          errors, checks, testsRun, testsFailed, errAtStart;
  int          cycleCount;
  int          seedDummy;

  apuTop dut0 (
    .clk, .reset, .ce, .addr, .din, .mw, .mr, .chanMask,
    .dout, .sample, .irq, .oddEven
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Watchdog
  initial begin
    cycleCount = 0;
    while (cycleCount < CYCLE_LIMIT) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
    $display("*** FAILED ***");
    $finish;
  end

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  function automatic logic [7:0] modelDout();
    return {1'b0, mFlag, 4'b0000, mLen[1] != 8'd0, mLen[0] != 8'd0};
  endfunction

  function automatic logic [4:0] regAddr(input int n, input int r);
    return 5'(n * 4 + r);
  endfunction

  // ----------------------------------------------------------
  // Model of one clock edge with the inputs just applied
  // ----------------------------------------------------------
  task automatic modelEdge(input logic [4:0] a, input logic [7:0] d,
                           input logic w, input logic r);
    logic       fWr, modeNow, inhNow, restart, q, h, nf, hit4;
    logic [7:0] nl;
    int         ns, nextHold;
    fWr     = w && (a == 5'h17);
    modeNow = fWr ? d[7] : mMode;
    inhNow  = fWr ? d[6] : mInhibit;
    for (int n = 0; n < 2; n++) begin
      nl = mLen[n];
      if (w && (a == regAddr(n, 3)))
        nl = lenRef[d[7:3]];
      if (mHalf && (mLen[n] != 8'd0) && !mHalt[n])
        nl = mLen[n] - 8'd1;
      if (!mEnable[n])
        nl = 8'd0;  // Old enable value applies
      mLen[n] = nl;
      if (w && (a == regAddr(n, 0)))
        mHalt[n] = d[5];
    end
    if (w && (a == 5'h15))
      mEnable = d[1:0];
    if (mHalf)
      halfSeen++;
    if (mQuarter)
      quarterSeen++;

    hit4 = (mStep == S4) && !modeNow;
    nf = mFlag;
    if (r && (a == 5'h15))
      nf = 1'b0;
    if (mHold != 0)
      nf = 1'b1;
    if (hit4)
      nf = 1'b1;
    if (inhNow)
      nf = 1'b0;
    nextHold = (mHold > 0) ? mHold - 1 : 0;
    if (hit4)
      nextHold = 2;

    q  = 1'b0;
    h  = 1'b0;
    ns = mStep + 1;
    if ((mStep == S1) || (mStep == S3))
      q = 1'b1;
    if (mStep == S2) begin
      q = 1'b1;
      h = 1'b1;
    end
    if (hit4 || (mStep == S5)) begin
      q  = 1'b1;
      h  = 1'b1;
      ns = 0;
    end
    restart  = mDelayed || (fWr && !mOdd);
    mDelayed = fWr && mOdd;
    if (restart) begin
      ns = 0;
      if (modeNow) begin
        q = 1'b1;
        h = 1'b1;
      end
    end
    mStep    = ns;
    mQuarter = q;
    mHalf    = h;
    mOdd     = !mOdd;
    mFlag    = nf;
    mHold    = nextHold;
    if (fWr) begin
      mMode    = d[7];
      mInhibit = d[6];
    end
  endtask

  // One clock cycle, called 2 ns after a rising edge
  task automatic step(input logic [4:0] a, input logic [7:0] d,
                      input logic w, input logic r);
    addr = a;
    din  = d;
    mw   = w;
    mr   = r;
    @(posedge clk);
    modelEdge(a, d, w, r);
    #2;
    mw = 1'b0;
    mr = 1'b0;
    checkValue("dout", dout, modelDout());
    checkValue("irq", irq, mFlag);
    checkValue("oddEven", oddEven, mOdd);
  endtask

  task automatic idle(input int count);
    repeat (count) step(5'd0, 8'd0, 1'b0, 1'b0);
  endtask

  task automatic finishTest(input string name);
    testsRun++;
    if (errors != errAtStart)
      testsFailed++;
    $display("Test %-18s %s", name, (errors != errAtStart) ? "failed" : "ok");
    errAtStart = errors;
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  task automatic testLengthStatus();
    int n;
    n = $urandom % 2;
    step(5'h15, 8'h03, 1'b1, 1'b0);
    step(regAddr(n, 3), 8'(($urandom % 32) << 3), 1'b1, 1'b0);
    idle(1);
    checkValue("dout[n] after load", dout[n], 1'b1);
    step(5'h15, (n == 0) ? 8'h02 : 8'h01, 1'b1, 1'b0);
    checkValue("dout[n] at disable", dout[n], 1'b1);
    idle(1);
    checkValue("dout[n] after disable", dout[n], 1'b0);
    finishTest("length/status");
  endtask

  task automatic testLengthCount(input logic five);
    int idx, base;
    idx = ($urandom % 2) ? 3 : 5;  // Loads of 2 or 4
    step(5'h15, 8'h01, 1'b1, 1'b0);
    step(5'h17, five ? 8'h80 : 8'h00, 1'b1, 1'b0);
    idle(3);
    step(regAddr(0, 0), 8'h00, 1'b1, 1'b0);  // Halt off
    step(regAddr(0, 3), 8'(idx << 3), 1'b1, 1'b0);
    base = halfSeen;
    while (dout[0])
      idle(1);
    checkValue("halfPulses", halfSeen - base, lenRef[idx]);
    finishTest(five ? "length 5-step" : "length 4-step");
  endtask

  task automatic testFrameIrq();
    int   c, expected;
    logic seen;
    step(5'h15, 8'h00, 1'b0, 1'b1);  // Clear a leftover flag
    idle(1);
    expected = mOdd ? 29831 : 29830;
    step(5'h17, 8'h00, 1'b1, 1'b0);
    c = 0;
    while (!irq) begin
      idle(1);
      c++;
    end
    checkValue("irqCycles", c, expected);
    idle(4);
    step(5'h15, 8'h00, 1'b0, 1'b1);
    checkValue("irq after read", irq, 1'b0);
    seen = 1'b0;
    step(5'h17, 8'h40, 1'b1, 1'b0);
    repeat (29840) begin
      idle(1);
      seen |= irq;
    end
    checkValue("irq inhibited", seen, 1'b0);
    step(5'h17, 8'h80, 1'b1, 1'b0);
    repeat (37290) begin
      idle(1);
      seen |= irq;
    end
    checkValue("irq 5-step", seen, 1'b0);
    finishTest("frame interrupt");
  endtask

  task automatic testMixing();
    logic [3:0]  vol [2];
    logic [1:0]  masks [4] = '{2'b11, 2'b01, 2'b10, 2'b00};
    logic [15:0] exp;
    int          per;
    step(5'h15, 8'h03, 1'b1, 1'b0);
    for (int n = 0; n < 2; n++) begin
      vol[n] = 4'($urandom % 16);
      per    = 8 + $urandom % 56;
      step(regAddr(n, 0), {2'($urandom % 4), 2'b11, vol[n]}, 1'b1, 1'b0);
      step(regAddr(n, 1), 8'h00, 1'b1, 1'b0);
      step(regAddr(n, 2), 8'(per), 1'b1, 1'b0);
      step(regAddr(n, 3), 8'h08, 1'b1, 1'b0);
    end
    for (int m = 0; m < 4; m++) begin
      chanMask = masks[m];
      idle(2);
      repeat (600) begin
        idle(1);
        // Any level pair on/off is legal, duty phase is not modeled
        exp = pulseRef[(masks[m][0] ? vol[0] : 0) + (masks[m][1] ? vol[1] : 0)];
        for (int a1 = 0; a1 < 2; a1++)
          for (int a2 = 0; a2 < 2; a2++)
            if (sample == pulseRef[((a1 && masks[m][0]) ? vol[0] : 0) +
                                   ((a2 && masks[m][1]) ? vol[1] : 0)])
              exp = sample;
        checkValue("sample", sample, exp);
      end
    end
    finishTest("mixing");
  endtask

  task automatic testInvalidPeriod();
    step(5'h15, 8'h01, 1'b1, 1'b0);
    step(regAddr(0, 0), 8'hBF, 1'b1, 1'b0);  // Const volume 15, halt
    step(regAddr(0, 1), 8'h00, 1'b1, 1'b0);
    step(regAddr(0, 2), 8'($urandom % 8), 1'b1, 1'b0);
    step(regAddr(0, 3), 8'h08, 1'b1, 1'b0);
    chanMask = 2'b01;
    idle(2);
    repeat (500) begin
      idle(1);
      checkValue("sample", sample, 16'd0);
    end
    checkValue("dout[0]", dout[0], 1'b1);
    finishTest("invalid period");
  endtask

  task automatic testEnvelope();
    int          base;
    logic [15:0] peak;
    peak = 16'd0;
    step(5'h15, 8'h01, 1'b1, 1'b0);
    step(5'h17, 8'h00, 1'b1, 1'b0);
    step(regAddr(0, 0), 8'h80, 1'b1, 1'b0);  // Envelope, volume 0
    step(regAddr(0, 2), 8'(8 + $urandom % 56), 1'b1, 1'b0);
    step(regAddr(0, 3), 8'h08, 1'b1, 1'b0);  // Load 254
    chanMask = 2'b01;
    base = quarterSeen;
    while (quarterSeen - base < 16) begin
      idle(1);
      if (sample > peak)
        peak = sample;
    end
    checkValue("envelope peak seen", peak != 16'd0, 1'b1);
    idle(2);
    repeat (1100) begin  // At least one full duty period
      idle(1);
      checkValue("sample", sample, 16'd0);
    end
    finishTest("envelope decay");
  endtask

  initial begin
    seedDummy = $urandom(91);
    reset = 1'b1;
    ce = 1'b1;
    addr = 5'd0;
    din = 8'd0;
    mw = 1'b0;
    mr = 1'b0;
    chanMask = 2'b00;
    mStep = 4;
    {mOdd, mDelayed, mQuarter, mHalf, mFlag, mMode, mInhibit} = '0;
    mHold = 0;
    mLen[0] = 8'd0;
    mLen[1] = 8'd0;
    mHalt = 2'b00;
    mEnable = 2'b00;
    {halfSeen, quarterSeen, errors, checks, testsRun, testsFailed, errAtStart} = '0;
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;

    testLengthStatus();
    testLengthCount(1'b0);
    testLengthCount(1'b1);
    testFrameIrq();
    testMixing();
    testInvalidPeriod();
    testEnvelope();

    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             testsRun, testsFailed, checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* apuTop.f */
src/apuPkg.sv
src/apuChanBus.sv
src/apuRegDecode.sv
src/apuFrameSeq.sv
src/apuPulseChan.sv
src/apuMixer.sv
src/apuTop.sv
dv/apuTb.sv

/* Makefile */
# Verilator flow for the pulse sound unit

VERILATOR ?= verilator
FILELIST  ?= apuTop.f
TB_TOP    ?= apuTb
RTL_TOP   ?= apuTop
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "^\*\*\* PASSED \*\*\*$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
